/* vlog.f */
logic/icache_pkg.sv
logic/ic_lookup.sv
logic/ic_miss_ctrl.sv
logic/ic_burst_reader.sv
logic/icache_top.sv
dv/icache_props.sv
dv/icache_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f --top-module icache_tb -Mdir obj_dir -o icache_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/icache_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
	exit 0
else
	echo "Pass message not found"
	exit 1
fi

/* dv/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb;

	localparam int ADDR_W = 32;
	localparam int SETS = 16;
	localparam int SETTLE_CYCLES = 3;
	// Bus memory returns address XOR key
	localparam logic [31:0] DATA_KEY = 32'h5a3c_96e1;
	localparam int FETCH_LIMIT = 200;
	localparam int WAIT_LIMIT = 40;

	logic clk;
	logic rst_i;
	logic fetch_vld_i;
	logic [ADDR_W-1:0] fetch_adr_i;
	logic inst_vld_o;
	logic [icache_pkg::WORD_W-1:0] inst_o;
	icache_pkg::fault_e inst_fault_o;
	logic stall_o;
	logic invline_i;
	logic [ADDR_W-1:0] invline_adr_i;
	logic [icache_pkg::MISS_CNT_W-1:0] miss_count_o;
	logic cyc_o;
	logic stb_o;
	icache_pkg::cti_e cti_o;
	logic [ADDR_W-1:0] adr_o;
	logic ack_i;
	logic err_i;
	logic [icache_pkg::WORD_W-1:0] dat_i;

	// Result counters
	int errors;
	int checks;

	// Bus model state
	logic [31:0] lfsr_q;
	int wait_left;
	bit armed;
	logic [31:0] beat_adr_q [$];
	icache_pkg::cti_e beat_cti_q [$];
	int err_beats;
	int cyc_cycles;

	icache_top #(
		.ADDR_W(ADDR_W),
		.SETS(SETS),
		.SETTLE_CYCLES(SETTLE_CYCLES)
	) dut_i (
		.clk(clk),
		.rst_i(rst_i),
		.fetch_vld_i(fetch_vld_i),
		.fetch_adr_i(fetch_adr_i),
		.inst_vld_o(inst_vld_o),
		.inst_o(inst_o),
		.inst_fault_o(inst_fault_o),
		.stall_o(stall_o),
		.invline_i(invline_i),
		.invline_adr_i(invline_adr_i),
		.miss_count_o(miss_count_o),
		.cyc_o(cyc_o),
		.stb_o(stb_o),
		.cti_o(cti_o),
		.adr_o(adr_o),
		.ack_i(ack_i),
		.err_i(err_i),
		.dat_i(dat_i)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ====================
	// Bus memory model
	// ====================

	// Galois LFSR with taps 32 30 26 25
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
	endfunction

	// One LFSR step per bit
	task automatic draw_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_q[0]};
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	function automatic logic [31:0] model_word(input logic [31:0] adr);
		return adr ^ DATA_KEY;
	endfunction

	// Word addresses that answer with err_i
	function automatic bit is_fault_adr(input logic [31:0] adr);
		case (adr)
			32'h0000_2008: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Slave answers each strobe after 0 to 3 idle cycles
	always @(posedge clk) begin
		logic [31:0] r;
		if (rst_i) begin
			ack_i <= 1'b0;
			err_i <= 1'b0;
			armed = 1'b0;
		end else begin
			if (cyc_o)
				cyc_cycles++;
			if (stb_o && (ack_i || err_i)) begin
				// Master takes the beat at this edge
				if (ack_i) begin
					beat_adr_q.push_back(adr_o);
					beat_cti_q.push_back(cti_o);
				end else begin
					err_beats++;
				end
				ack_i <= 1'b0;
				err_i <= 1'b0;
				armed = 1'b0;
			end else if (stb_o) begin
				if (!armed) begin
					draw_bits(2, r);
					wait_left = int'(r);
					armed = 1'b1;
				end
				if (wait_left == 0) begin
					if (is_fault_adr(adr_o)) begin
						err_i <= 1'b1;
					end else begin
						ack_i <= 1'b1;
						dat_i <= model_word(adr_o);
					end
				end else begin
					wait_left--;
				end
			end
		end
	end

	task automatic clear_bus_log();
		beat_adr_q.delete();
		beat_cti_q.delete();
		err_beats = 0;
	endtask

	// ====================
	// Checking
	// ====================

	task automatic compare_word(input string name, input logic [icache_pkg::WORD_W-1:0] got,
			input logic [icache_pkg::WORD_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			$display("Fail %0t %s: got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_fault(input string name, input icache_pkg::fault_e got,
			input icache_pkg::fault_e exp);
		checks++;
		if (got !== exp) begin
			$display("Fail %0t %s: got %s (%0d) expected %s (%0d)", $time, name,
				got.name(), got, exp.name(), exp);
			errors++;
		end
	endtask

	task automatic compare_cti(input string name, input icache_pkg::cti_e got,
			input icache_pkg::cti_e exp);
		checks++;
		if (got !== exp) begin
			$display("Fail %0t %s: got %s (%0d) expected %s (%0d)", $time, name,
				got.name(), got, exp.name(), exp);
			errors++;
		end
	endtask

	task automatic compare_count(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("Fail %0t %s: got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic report_failure(input string msg);
		$display("%0t: %s", $time, msg);
		errors++;
	endtask

	task automatic report_test(input string name, input int start_errs);
		if (errors == start_errs)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - start_errs);
	endtask

	// ====================
	// Drivers
	// ====================

	// Holds the strobe through any stall until the word comes back
	task automatic fetch_word(input logic [31:0] adr, output logic [31:0] word,
			output icache_pkg::fault_e fault, output bit stalled);
		int n;
		bit got;
		n = 0;
		got = 1'b0;
		stalled = 1'b0;
		word = '0;
		fault = icache_pkg::FAULT_NONE;
		@(posedge clk);
		fetch_vld_i <= 1'b1;
		fetch_adr_i <= adr;
		while (!got && n < FETCH_LIMIT) begin
			@(negedge clk);
			n++;
			if (stall_o)
				stalled = 1'b1;
			if (inst_vld_o) begin
				got = 1'b1;
				word = inst_o;
				fault = inst_fault_o;
			end
		end
		@(posedge clk);
		fetch_vld_i <= 1'b0;
		@(negedge clk);
		if (!got)
			report_failure($sformatf("No instruction returned for address %h", adr));
	endtask

	task automatic wait_stall(input logic level, input string what);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (stall_o !== level && n < WAIT_LIMIT);
		if (stall_o !== level)
			report_failure($sformatf("stall_o never became %0b during %s", level, what));
	endtask

	// ====================
	// Directed tests
	// ====================

	task automatic reset_state();
		int start_errs;
		start_errs = errors;
		compare_count("stall_o", 32'(stall_o), 0);
		compare_count("cyc_o", 32'(cyc_o), 0);
		compare_count("stb_o", 32'(stb_o), 0);
		compare_count("inst_vld_o", 32'(inst_vld_o), 0);
		compare_cti("cti_o", cti_o, icache_pkg::CTI_CLASSIC);
		compare_count("miss_count_o", miss_count_o, 0);
		report_test("reset state", start_errs);
	endtask

	task automatic cold_miss_fill();
		logic [31:0] adr;
		logic [31:0] word;
		logic [31:0] count0;
		icache_pkg::fault_e fault;
		bit stalled;
		int i;
		int start_errs;
		start_errs = errors;
		count0 = miss_count_o;
		clear_bus_log();
		for (i = 0; i < 4; i++) begin
			adr = 32'h0000_1040 + 32'(4 * i);
			fetch_word(adr, word, fault, stalled);
			compare_word($sformatf("inst_o at %h", adr), word, model_word(adr));
			compare_fault("inst_fault_o", fault, icache_pkg::FAULT_NONE);
			// Only the first word misses
			compare_count("stall seen", 32'(stalled), (i == 0) ? 1 : 0);
		end
		compare_count("miss_count_o", miss_count_o, count0 + 1);
		compare_count("acknowledged beats", beat_adr_q.size(), 4);
		report_test("cold miss fill", start_errs);
	endtask

	task automatic hit_latency();
		logic [31:0] adr;
		logic [31:0] word;
		icache_pkg::fault_e fault;
		int lat;
		int cyc0;
		bit seen;
		int start_errs;
		adr = 32'h0000_1048;
		start_errs = errors;
		cyc0 = cyc_cycles;
		lat = 0;
		seen = 1'b0;
		word = '0;
		fault = icache_pkg::FAULT_NONE;
		// Single-cycle strobe
		@(posedge clk);
		fetch_vld_i <= 1'b1;
		fetch_adr_i <= adr;
		while (!seen && lat < WAIT_LIMIT) begin
			@(posedge clk);
			fetch_vld_i <= 1'b0;
			lat++;
			@(negedge clk);
			if (inst_vld_o) begin
				seen = 1'b1;
				word = inst_o;
				fault = inst_fault_o;
			end
		end
		if (!seen) begin
			report_failure($sformatf("Hit on %h never returned inst_vld_o", adr));
		end else begin
			compare_count("hit latency", lat, 1);
			compare_word("inst_o on hit", word, model_word(adr));
			compare_fault("inst_fault_o on hit", fault, icache_pkg::FAULT_NONE);
		end
		compare_count("bus cycles during hit", cyc_cycles - cyc0, 0);
		report_test("hit latency", start_errs);
	endtask

	task automatic burst_shape();
		logic [31:0] base;
		logic [31:0] word;
		icache_pkg::fault_e fault;
		bit stalled;
		int n;
		int i;
		int start_errs;
		start_errs = errors;
		for (n = 0; n < 2; n++) begin
			base = (n == 0) ? 32'h0000_3a70 : 32'h0000_0e80;
			clear_bus_log();
			// Burst for a middle word still starts at the line base
			fetch_word(base + 32'h4, word, fault, stalled);
			compare_word("inst_o", word, model_word(base + 32'h4));
			compare_count("acknowledged beats", beat_adr_q.size(), 4);
			if (beat_adr_q.size() == 4) begin
				for (i = 0; i < 4; i++) begin
					compare_word($sformatf("adr_o beat %0d", i + 1), beat_adr_q[i],
						base + 32'(4 * i));
					compare_cti($sformatf("cti_o beat %0d", i + 1), beat_cti_q[i],
						(i == 3) ? icache_pkg::CTI_END : icache_pkg::CTI_INCR);
				end
			end
			compare_count("cyc_o after burst", 32'(cyc_o), 0);
		end
		report_test("burst shape", start_errs);
	endtask

	task automatic bus_error_fill();
		logic [31:0] word;
		logic [31:0] count0;
		icache_pkg::fault_e fault;
		bit stalled;
		int cyc0;
		int start_errs;
		start_errs = errors;
		count0 = miss_count_o;
		clear_bus_log();
		// Third beat of this line errors
		fetch_word(32'h0000_2004, word, fault, stalled);
		compare_word("inst_o on faulted line", word, icache_pkg::NOP_WORD);
		compare_fault("inst_fault_o on faulted line", fault, icache_pkg::FAULT_BUS);
		compare_count("miss_count_o", miss_count_o, count0 + 1);
		compare_count("beats before error", beat_adr_q.size(), 2);
		compare_count("error beats", err_beats, 1);
		// Refetch hits the stored fault
		cyc0 = cyc_cycles;
		fetch_word(32'h0000_200c, word, fault, stalled);
		compare_word("inst_o on refetch", word, icache_pkg::NOP_WORD);
		compare_fault("inst_fault_o on refetch", fault, icache_pkg::FAULT_BUS);
		compare_count("stall on refetch", 32'(stalled), 0);
		compare_count("bus cycles on refetch", cyc_cycles - cyc0, 0);
		report_test("bus error", start_errs);
	endtask

	task automatic invalidate_refill();
		logic [31:0] word;
		logic [31:0] count0;
		icache_pkg::fault_e fault;
		bit stalled;
		int start_errs;
		start_errs = errors;
		// Line cached by the cold miss test
		@(posedge clk);
		invline_i <= 1'b1;
		invline_adr_i <= 32'h0000_1048;
		@(posedge clk);
		invline_i <= 1'b0;
		wait_stall(1'b1, "invalidate");
		wait_stall(1'b0, "invalidate");
		count0 = miss_count_o;
		clear_bus_log();
		fetch_word(32'h0000_1044, word, fault, stalled);
		compare_word("inst_o after invalidate", word, model_word(32'h0000_1044));
		compare_count("stall after invalidate", 32'(stalled), 1);
		compare_count("acknowledged beats", beat_adr_q.size(), 4);
		compare_count("miss_count_o", miss_count_o, count0 + 1);
		report_test("invalidate", start_errs);
	endtask

	task automatic set_conflict();
		logic [31:0] adr;
		logic [31:0] word;
		logic [31:0] count0;
		icache_pkg::fault_e fault;
		bit stalled;
		int i;
		int start_errs;
		start_errs = errors;
		count0 = miss_count_o;
		// Both lines index set 5
		for (i = 0; i < 4; i++) begin
			adr = (i % 2 == 0) ? 32'h0000_5050 : 32'h0000_6058;
			clear_bus_log();
			fetch_word(adr, word, fault, stalled);
			compare_word($sformatf("inst_o at %h", adr), word, model_word(adr));
			compare_fault("inst_fault_o", fault, icache_pkg::FAULT_NONE);
			compare_count("acknowledged beats", beat_adr_q.size(), 4);
		end
		compare_count("miss_count_o", miss_count_o, count0 + 4);
		report_test("set conflict", start_errs);
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		errors = 0;
		checks = 0;
		lfsr_q = 32'h20d3_d68d;
		wait_left = 0;
		armed = 1'b0;
		err_beats = 0;
		cyc_cycles = 0;
		rst_i = 1'b1;
		fetch_vld_i = 1'b0;
		fetch_adr_i = '0;
		invline_i = 1'b0;
		invline_adr_i = '0;
		ack_i = 1'b0;
		err_i = 1'b0;
		dat_i = '0;
		repeat (3) @(posedge clk);
		rst_i <= 1'b0;
		@(negedge clk);

		reset_state();
		cold_miss_fill();
		hit_latency();
		burst_shape();
		bus_error_fill();
		invalidate_refill();
		set_conflict();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* dv/icache_props.sv */
`timescale 1ns/1ps

module icache_props (
	input logic clk,
	input logic rst_i,
	input logic stall_o,
	input logic cyc_o,
	input logic stb_o,
	input icache_pkg::cti_e cti_o,
	input logic ack_i
);

	// ====================
	// Bus protocol
	// ====================

	// Strobe only inside a cycle
	stb_in_cyc: assert property (@(posedge clk) disable iff (rst_i) stb_o |-> cyc_o)
		else $error("stb_o high without cyc_o");

	// Idle bus carries a classic cycle tag
	cti_idle: assert property (@(posedge clk) disable iff (rst_i)
		!cyc_o |-> cti_o == icache_pkg::CTI_CLASSIC)
		else $error("cti_o not classic while cyc_o is low");

	// Last beat ends the cycle
	end_drops_cyc: assert property (@(posedge clk) disable iff (rst_i)
		(stb_o && ack_i && cti_o == icache_pkg::CTI_END) |=> !cyc_o)
		else $error("cyc_o still high after the end beat");

	// Reset state
	reset_quiet: assert property (@(posedge clk) rst_i |=> (!stall_o && !cyc_o))
		else $error("stall_o or cyc_o high after reset");

endmodule

bind icache_top icache_props props_i (
	.clk(clk),
	.rst_i(rst_i),
	.stall_o(stall_o),
	.cyc_o(cyc_o),
	.stb_o(stb_o),
	.cti_o(cti_o),
	.ack_i(ack_i)
);

/* logic/icache_top.sv */
`timescale 1ns/1ps

module icache_top #(
	parameter int ADDR_W = 32,
	parameter int SETS = 16,
	parameter int SETTLE_CYCLES = 3
) (
	input logic clk,
	input logic rst_i,
	// Fetch port
	input logic fetch_vld_i,
	input logic [ADDR_W-1:0] fetch_adr_i,
	output logic inst_vld_o,
	output logic [icache_pkg::WORD_W-1:0] inst_o,
	output icache_pkg::fault_e inst_fault_o,
	output logic stall_o,
	// Line invalidate
	input logic invline_i,
	input logic [ADDR_W-1:0] invline_adr_i,
	output logic [icache_pkg::MISS_CNT_W-1:0] miss_count_o,
	// Wishbone burst master
	output logic cyc_o,
	output logic stb_o,
	output icache_pkg::cti_e cti_o,
	output logic [ADDR_W-1:0] adr_o,
	input logic ack_i,
	input logic err_i,
	input logic [icache_pkg::WORD_W-1:0] dat_i
);

	// ====================
	// Internal nets
	// ====================

	logic busy;
	logic miss;
	logic [ADDR_W-1:0] miss_adr;
	logic inval;
	logic [ADDR_W-1:0] inval_adr;
	logic fill_wr;
	logic [ADDR_W-1:0] fill_adr;
	logic [icache_pkg::LINE_W-1:0] fill_line;
	icache_pkg::fault_e fill_fault;
	// Controller to burst reader
	logic start;
	logic [ADDR_W-1:0] line_adr;
	logic done;
	logic [icache_pkg::LINE_W-1:0] line;
	icache_pkg::fault_e fault;

	ic_lookup #(
		.ADDR_W(ADDR_W),
		.SETS(SETS)
	) lookup_i (
		.clk(clk),
		.rst_i(rst_i),
		.fetch_vld_i(fetch_vld_i),
		.fetch_adr_i(fetch_adr_i),
		.busy_i(busy),
		.fill_wr_i(fill_wr),
		.fill_adr_i(fill_adr),
		.fill_line_i(fill_line),
		.fill_fault_i(fill_fault),
		.inval_i(inval),
		.inval_adr_i(inval_adr),
		.inst_vld_o(inst_vld_o),
		.inst_o(inst_o),
		.inst_fault_o(inst_fault_o),
		.miss_o(miss),
		.miss_adr_o(miss_adr)
	);

	ic_miss_ctrl #(
		.ADDR_W(ADDR_W),
		.SETTLE_CYCLES(SETTLE_CYCLES)
	) miss_ctrl_i (
		.clk(clk),
		.rst_i(rst_i),
		.miss_i(miss),
		.miss_adr_i(miss_adr),
		.invline_i(invline_i),
		.invline_adr_i(invline_adr_i),
		.done_i(done),
		.line_i(line),
		.fault_i(fault),
		.busy_o(busy),
		.stall_o(stall_o),
		.start_o(start),
		.line_adr_o(line_adr),
		.inval_o(inval),
		.inval_adr_o(inval_adr),
		.fill_wr_o(fill_wr),
		.fill_adr_o(fill_adr),
		.fill_line_o(fill_line),
		.fill_fault_o(fill_fault),
		.miss_count_o(miss_count_o)
	);

	ic_burst_reader #(
		.ADDR_W(ADDR_W)
	) burst_reader_i (
		.clk(clk),
		.rst_i(rst_i),
		.start_i(start),
		.line_adr_i(line_adr),
		.ack_i(ack_i),
		.err_i(err_i),
		.dat_i(dat_i),
		.done_o(done),
		.line_o(line),
		.fault_o(fault),
		.cyc_o(cyc_o),
		.stb_o(stb_o),
		.cti_o(cti_o),
		.adr_o(adr_o)
	);

endmodule

/* logic/ic_burst_reader.sv */
`timescale 1ns/1ps

module ic_burst_reader #(
	parameter int ADDR_W = 32
) (
	input logic clk,
	input logic rst_i,
	// Line request from controller
	input logic start_i,
	input logic [ADDR_W-1:0] line_adr_i,
	// Bus slave response
	input logic ack_i,
	input logic err_i,
	input logic [icache_pkg::WORD_W-1:0] dat_i,
	// Line result
	output logic done_o,
	output logic [icache_pkg::LINE_W-1:0] line_o,
	output icache_pkg::fault_e fault_o,
	// Bus master
	output logic cyc_o,
	output logic stb_o,
	output icache_pkg::cti_e cti_o,
	output logic [ADDR_W-1:0] adr_o
);

	localparam int OFF_W = icache_pkg::LINE_OFF_W;
	localparam int BEAT_W = icache_pkg::BEAT_W;
	localparam int WORD_W = icache_pkg::WORD_W;
	localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(icache_pkg::LINE_WORDS - 1);

	logic [BEAT_W-1:0] beat_q;
	logic beat_ok;
	logic beat_err;

	// Word transferred or burst aborted this cycle
	assign beat_ok = stb_o & ack_i & ~err_i;
	assign beat_err = cyc_o & err_i;

	// ====================
	// Bus control
	// ====================

	always_ff @(posedge clk) begin
		if (rst_i) begin
			cyc_o <= 1'b0;
			stb_o <= 1'b0;
			cti_o <= icache_pkg::CTI_CLASSIC;
			done_o <= 1'b0;
			beat_q <= '0;
		end else begin
			done_o <= 1'b0;
			if (beat_err) begin
				// Abort at once
				cyc_o <= 1'b0;
				stb_o <= 1'b0;
				cti_o <= icache_pkg::CTI_CLASSIC;
				done_o <= 1'b1;
			end else if (beat_ok) begin
				beat_q <= beat_q + 1'b1;
				// Tag the final beat
				if (beat_q == LAST_BEAT - 1'b1)
					cti_o <= icache_pkg::CTI_END;
				if (beat_q == LAST_BEAT) begin
					cyc_o <= 1'b0;
					stb_o <= 1'b0;
					cti_o <= icache_pkg::CTI_CLASSIC;
					done_o <= 1'b1;
				end
			end else if (start_i && !cyc_o) begin
				cyc_o <= 1'b1;
				stb_o <= 1'b1;
				cti_o <= icache_pkg::CTI_INCR;
				beat_q <= '0;
			end
		end
	end

	// Address, line assembly and fault code
	always_ff @(posedge clk) begin
		if (beat_err) begin
			// Bad line reads as no-ops
			line_o <= {icache_pkg::LINE_WORDS{icache_pkg::NOP_WORD}};
			fault_o <= icache_pkg::FAULT_BUS;
		end else if (beat_ok) begin
			line_o[beat_q*WORD_W +: WORD_W] <= dat_i;
			adr_o <= adr_o + ADDR_W'(icache_pkg::WORD_BYTES);
		end else if (start_i && !cyc_o) begin
			// Burst always starts at the line base
			adr_o <= {line_adr_i[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
			fault_o <= icache_pkg::FAULT_NONE;
		end
	end

endmodule

/* logic/ic_miss_ctrl.sv */
`timescale 1ns/1ps

module ic_miss_ctrl #(
	parameter int ADDR_W = 32,
	parameter int SETTLE_CYCLES = 3
) (
	input logic clk,
	input logic rst_i,
	// From lookup
	input logic miss_i,
	input logic [ADDR_W-1:0] miss_adr_i,
	// Line invalidate request
	input logic invline_i,
	input logic [ADDR_W-1:0] invline_adr_i,
	// From burst reader
	input logic done_i,
	input logic [icache_pkg::LINE_W-1:0] line_i,
	input icache_pkg::fault_e fault_i,
	// Fetch control
	output logic busy_o,
	output logic stall_o,
	// To burst reader
	output logic start_o,
	output logic [ADDR_W-1:0] line_adr_o,
	// To lookup arrays
	output logic inval_o,
	output logic [ADDR_W-1:0] inval_adr_o,
	output logic fill_wr_o,
	output logic [ADDR_W-1:0] fill_adr_o,
	output logic [icache_pkg::LINE_W-1:0] fill_line_o,
	output icache_pkg::fault_e fill_fault_o,
	output logic [icache_pkg::MISS_CNT_W-1:0] miss_count_o
);

	localparam int CNT_W = $clog2(SETTLE_CYCLES + 1);
	localparam logic [CNT_W-1:0] SETTLE_LAST = CNT_W'(SETTLE_CYCLES - 1);

	icache_pkg::ic_state_e state_q;
	logic [CNT_W-1:0] settle_cnt_q;
	// Invalidate waiting for IDLE
	logic inval_pend_q;
	logic [ADDR_W-1:0] inval_pend_adr_q;

	// Decisions taken this cycle
	logic take_inval;
	logic take_miss;
	logic fill_done;

	// Invalidate beats a miss in the same cycle
	assign take_inval = (state_q == icache_pkg::IDLE) && inval_pend_q;
	assign take_miss = (state_q == icache_pkg::IDLE) && !inval_pend_q && miss_i;
	assign fill_done = (state_q == icache_pkg::FILL) && done_i;

	// Fetches wait in every state but IDLE
	assign stall_o = (state_q != icache_pkg::IDLE);
	assign busy_o = stall_o;

	// Fill writes back to the line that was requested
	assign fill_adr_o = line_adr_o;

	// ====================
	// State machine
	// ====================

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= icache_pkg::IDLE;
			settle_cnt_q <= '0;
			inval_pend_q <= 1'b0;
			start_o <= 1'b0;
			inval_o <= 1'b0;
			fill_wr_o <= 1'b0;
			miss_count_o <= '0;
		end else begin
			// Pulses default low
			start_o <= 1'b0;
			inval_o <= 1'b0;
			fill_wr_o <= 1'b0;

			// A new request in the serving cycle stays pending
			if (take_inval)
				inval_pend_q <= 1'b0;
			if (invline_i)
				inval_pend_q <= 1'b1;

			case (state_q)
				icache_pkg::IDLE: begin
					if (take_inval) begin
						inval_o <= 1'b1;
						state_q <= icache_pkg::INVAL;
					end else if (take_miss) begin
						start_o <= 1'b1;
						state_q <= icache_pkg::FILL;
					end
				end
				// One cycle for the valid bit to clear
				icache_pkg::INVAL: state_q <= icache_pkg::IDLE;
				icache_pkg::FILL: begin
					// Faulted fills count too
					if (done_i) begin
						fill_wr_o <= 1'b1;
						miss_count_o <= miss_count_o + 1'b1;
						state_q <= icache_pkg::WRITE;
					end
				end
				icache_pkg::WRITE: begin
					settle_cnt_q <= '0;
					state_q <= icache_pkg::SETTLE;
				end
				// Let the array write settle before the refetch
				icache_pkg::SETTLE: begin
					if (settle_cnt_q == SETTLE_LAST)
						state_q <= icache_pkg::IDLE;
					else
						settle_cnt_q <= settle_cnt_q + 1'b1;
				end
				default: state_q <= icache_pkg::IDLE;
			endcase
		end
	end

	// Addresses and line payload
	always_ff @(posedge clk) begin
		if (invline_i)
			inval_pend_adr_q <= invline_adr_i;
		if (take_inval)
			inval_adr_o <= inval_pend_adr_q;
		if (take_miss)
			line_adr_o <= miss_adr_i;
		if (fill_done) begin
			fill_line_o <= line_i;
			fill_fault_o <= fault_i;
		end
	end

endmodule

/* logic/ic_lookup.sv */
`timescale 1ns/1ps

module ic_lookup #(
	parameter int ADDR_W = 32,
	parameter int SETS = 16
) (
	input logic clk,
	input logic rst_i,
	// Fetch request, one-cycle strobe
	input logic fetch_vld_i,
	input logic [ADDR_W-1:0] fetch_adr_i,
	// Controller is busy with a miss or an invalidate
	input logic busy_i,
	// Line fill write port
	input logic fill_wr_i,
	input logic [ADDR_W-1:0] fill_adr_i,
	input logic [icache_pkg::LINE_W-1:0] fill_line_i,
	input icache_pkg::fault_e fill_fault_i,
	// Single line invalidate
	input logic inval_i,
	input logic [ADDR_W-1:0] inval_adr_i,
	// Hit result
	output logic inst_vld_o,
	output logic [icache_pkg::WORD_W-1:0] inst_o,
	output icache_pkg::fault_e inst_fault_o,
	// Miss result
	output logic miss_o,
	output logic [ADDR_W-1:0] miss_adr_o
);

	localparam int OFF_W = icache_pkg::LINE_OFF_W;
	localparam int IDX_W = $clog2(SETS);
	localparam int TAG_W = ADDR_W - IDX_W - OFF_W;
	localparam int WORD_W = icache_pkg::WORD_W;

	// ====================
	// Arrays
	// ====================

	logic [TAG_W-1:0] tag_mem [SETS];
	logic [icache_pkg::LINE_W-1:0] data_mem [SETS];
	icache_pkg::fault_e fault_mem [SETS];
	// Valid bits live in flops so reset can clear them all at once
	logic [SETS-1:0] valid_q;

	// Address fields
	logic [IDX_W-1:0] fetch_idx;
	logic [IDX_W-1:0] fill_idx;
	logic [IDX_W-1:0] inval_idx;
	logic [TAG_W-1:0] fill_tag;
	logic [TAG_W-1:0] inval_tag;
	logic [TAG_W-1:0] req_tag;
	logic [icache_pkg::BEAT_W-1:0] word_sel;

	// Registered lookup stage
	logic req_q;
	logic [ADDR_W-1:0] req_adr_q;
	logic [TAG_W-1:0] rd_tag_q;
	logic rd_valid_q;
	logic [icache_pkg::LINE_W-1:0] rd_line_q;
	icache_pkg::fault_e rd_fault_q;
	logic hit;

	assign fetch_idx = fetch_adr_i[OFF_W +: IDX_W];
	assign fill_idx = fill_adr_i[OFF_W +: IDX_W];
	assign inval_idx = inval_adr_i[OFF_W +: IDX_W];
	assign fill_tag = fill_adr_i[ADDR_W-1 -: TAG_W];
	assign inval_tag = inval_adr_i[ADDR_W-1 -: TAG_W];

	// Fill writes tag, data and fault together
	always_ff @(posedge clk) begin
		if (fill_wr_i) begin
			tag_mem[fill_idx] <= fill_tag;
			data_mem[fill_idx] <= fill_line_i;
			fault_mem[fill_idx] <= fill_fault_i;
		end
	end

	// Valid bits
	// Invalidate only hits the line if the stored tag matches
	always_ff @(posedge clk) begin
		if (rst_i) begin
			valid_q <= '0;
		end else if (fill_wr_i) begin
			valid_q[fill_idx] <= 1'b1;
		end else if (inval_i && tag_mem[inval_idx] == inval_tag) begin
			valid_q[inval_idx] <= 1'b0;
		end
	end

	// ====================
	// Lookup stage
	// ====================

	// Requests are dropped while the controller is busy
	always_ff @(posedge clk) begin
		if (rst_i) begin
			req_q <= 1'b0;
		end else begin
			req_q <= fetch_vld_i & ~busy_i;
		end
	end

	// Set read, compared one cycle later
	always_ff @(posedge clk) begin
		req_adr_q <= fetch_adr_i;
		rd_tag_q <= tag_mem[fetch_idx];
		rd_valid_q <= valid_q[fetch_idx];
		rd_line_q <= data_mem[fetch_idx];
		rd_fault_q <= fault_mem[fetch_idx];
	end

	assign req_tag = req_adr_q[ADDR_W-1 -: TAG_W];
	assign hit = rd_valid_q && (rd_tag_q == req_tag);

	// Word within the line
	assign word_sel = req_adr_q[icache_pkg::WORD_OFF_W +: icache_pkg::BEAT_W];
	assign inst_o = rd_line_q[word_sel*WORD_W +: WORD_W];
	assign inst_fault_o = rd_fault_q;
	assign inst_vld_o = req_q & hit;

	// Miss hands the line-aligned address to the controller
	assign miss_o = req_q & ~hit;
	assign miss_adr_o = {req_adr_q[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};

endmodule

/* logic/icache_pkg.sv */
package icache_pkg;

	// ====================
	// Line geometry
	// ====================

	// Instruction word
	localparam int WORD_W = 32;
	localparam int WORD_BYTES = WORD_W / 8;
	// Byte offset of a word within its line
	localparam int WORD_OFF_W = $clog2(WORD_BYTES);

	// Four words per line, one burst beat each
	localparam int LINE_WORDS = 4;
	localparam int LINE_W = WORD_W * LINE_WORDS;
	localparam int BEAT_W = $clog2(LINE_WORDS);
	// Byte offset within a line, 4 bits for a 16-byte line
	localparam int LINE_OFF_W = $clog2(LINE_WORDS * WORD_BYTES);

	// Completed fill counter
	localparam int MISS_CNT_W = 32;

	// Filler for a line that came back with a bus error
	localparam logic [WORD_W-1:0] NOP_WORD = 32'h0000_0013;

	// ====================
	// Encodings
	// ====================

	// Miss controller states
	typedef enum logic [2:0] {
		IDLE,
		INVAL,
		FILL,
		WRITE,
		SETTLE
	} ic_state_e;

	// Wishbone cycle type tag
	typedef enum logic [2:0] {
		CTI_CLASSIC = 3'b000,
		CTI_INCR = 3'b010,
		CTI_END = 3'b111
	} cti_e;

	// Stored with each line, returned with each word
	typedef enum logic [1:0] {
		FAULT_NONE = 2'd0,
		FAULT_BUS = 2'd3
	} fault_e;

endpackage
